// File: common/huff_pkg.sv
package huff_pkg;

    // tree sizes
    localparam int unsigned NODE_COUNT = 128;  // internal nodes held
    localparam int unsigned SYM_COUNT  = 256;  // one table entry per byte symbol
    localparam int unsigned CODE_W     = 24;   // code bits field, CODE_BITS must not exceed it

    typedef logic [6:0] node_idx_t;  // internal node index
    typedef logic [7:0] sym_t;       // leaf symbol

    // bit 8 set = internal node, index in 6:0
    // bit 8 clear = leaf, symbol in 7:0
    typedef logic [8:0] child_t;

    typedef struct packed {
        child_t left;   // code bit 0
        child_t right;  // code bit 1
    } htree_node_t;

    typedef logic [4:0]        code_len_t;   // code length in bits
    typedef logic [CODE_W-1:0] code_bits_t;  // right aligned, first branch on top

    // one code table word
    typedef struct packed {
        code_len_t  len;
        code_bits_t bits;
    } cb_entry_t;

    // leaf record from the walk to the table
    typedef struct packed {
        logic      valid;  // one cycle per leaf
        sym_t      sym;
        cb_entry_t entry;
    } cb_write_t;

    typedef enum logic [2:0] {
        INIT,       // wait for table clear, load root
        LEFT,       // try left child
        TRACK,      // re-walk from root
        BACKTRACK,  // pop moves
        RIGHT,      // try right child
        FINISH      // walk done, also idle
    } cb_state_t;

    // AXI4-Lite words
    typedef logic [31:0] axi_data_t;
    typedef logic [1:0]  axi_resp_t;

    localparam axi_resp_t RESP_OKAY = 2'b00;

    // register map, byte offsets
    localparam int unsigned CTRL_ADDR   = 'h000;          // bit 0 start, 14:8 root
    localparam int unsigned STATUS_ADDR = 'h004;          // bit 0 busy, bit 1 done
    localparam int unsigned NODE_BASE   = 'h400;          // node n at base + 4n
    localparam int unsigned NODE_SPAN   = 4 * NODE_COUNT;
    localparam int unsigned CODE_BASE   = 'h800;          // symbol s at base + 4s
    localparam int unsigned CODE_SPAN   = 4 * SYM_COUNT;

endpackage

// File: verilog/axil_regs.sv
`timescale 1ns/1ps

module axil_regs import huff_pkg::*; #(
    parameter int ADDR_W = 12
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [ADDR_W-1:0] awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  axi_data_t         wdata,
    input  logic              wvalid,
    output logic              wready,
    output axi_resp_t         bresp,
    output logic              bvalid,
    input  logic              bready,
    input  logic [ADDR_W-1:0] araddr,
    input  logic              arvalid,
    output logic              arready,
    output axi_data_t         rdata,
    output axi_resp_t         rresp,
    output logic              rvalid,
    input  logic              rready,
    output logic              start,
    output node_idx_t         root,
    input  logic              busy,
    input  logic              done,
    output logic              node_we,
    output node_idx_t         node_addr,
    output htree_node_t       node_wdata,
    output sym_t              tab_raddr,
    input  cb_entry_t         tab_rdata
);

    logic      wr_fire;    // aw and w taken this cycle
    logic      rd_fire;    // ar taken this cycle
    logic      wr_start;   // accepted start request
    logic      rd_code;    // read hits the code window
    logic      code_pend;  // table read in flight
    axi_data_t rd_word;    // ctrl/status read mux

    function automatic logic in_window(logic [ADDR_W-1:0] a, int unsigned base,
                                       int unsigned span);
        return (a >= ADDR_W'(base)) && (a < ADDR_W'(base + span));
    endfunction

    assign wready  = awready;  // aw and w accepted as a pair
    assign bresp   = RESP_OKAY;
    assign rresp   = RESP_OKAY;
    assign wr_fire = awready && awvalid && wvalid;
    assign rd_fire = arready && arvalid;

    // start is dropped while a walk runs
    assign wr_start = wr_fire && (awaddr == ADDR_W'(CTRL_ADDR)) && wdata[0] && !busy;

    // node window goes straight to the memory write port
    assign node_we    = wr_fire && in_window(awaddr, NODE_BASE, NODE_SPAN);
    assign node_addr  = node_idx_t'(awaddr[8:2]);
    assign node_wdata = '{left: wdata[8:0], right: wdata[17:9]};

    assign rd_code   = in_window(araddr, CODE_BASE, CODE_SPAN);
    assign tab_raddr = sym_t'(araddr[9:2]);  // table sees the address in the ar cycle

    always_comb begin
        rd_word = '0;  // node window and holes read zero
        if (araddr == ADDR_W'(CTRL_ADDR)) begin
            rd_word[14:8] = root;
        end else if (araddr == ADDR_W'(STATUS_ADDR)) begin
            rd_word[1:0] = {done, busy};
        end
    end

    // write channel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            awready <= 1'b0;
            bvalid  <= 1'b0;
            start   <= 1'b0;
            root    <= '0;
        end else begin
            awready <= awvalid && wvalid && !awready && !bvalid;  // one-cycle ready
            start   <= wr_start;                                  // one-cycle pulse
            if (wr_start) begin
                root <= wdata[14:8];
            end
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;  // held until the master takes it
            end
        end
    end

    // read channel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arready   <= 1'b0;
            rvalid    <= 1'b0;
            code_pend <= 1'b0;
        end else begin
            arready   <= arvalid && !arready && !rvalid && !code_pend;
            code_pend <= rd_fire && rd_code;  // one extra cycle for the table
            if ((rd_fire && !rd_code) || code_pend) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire && !rd_code) begin
            rdata <= rd_word;
        end else if (code_pend) begin
            rdata <= axi_data_t'(tab_rdata);  // len in 28:24, code in 23:0
        end
    end

endmodule

// File: verilog/htree_mem.sv
`timescale 1ns/1ps

// tree node store
// host writes nodes over AXI, the walk reads them one cycle later
module htree_mem import huff_pkg::*; (
    input  logic        clk,
    input  logic        we,     // host write strobe
    input  node_idx_t   waddr,  // host node index
    input  htree_node_t wdata,  // both children of the node
    input  node_idx_t   raddr,  // walk node index
    output htree_node_t rdata   // node at raddr, one cycle later
);

    htree_node_t mem [NODE_COUNT];  // contents undefined until the host loads a tree

    // host port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // walk port, registered
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];  // read-before-write on a same-address collision
    end

endmodule

// File: codebook/cb_synthesis.sv
`timescale 1ns/1ps

module cb_synthesis import huff_pkg::*; #(
    parameter int CODE_BITS = 24
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,       // one-cycle pulse, already gated by busy
    input  node_idx_t   root,        // root node index, valid with start
    input  logic        clear_busy,  // code table still wiping
    output node_idx_t   node_addr,   // walk read address
    input  htree_node_t node,        // node at node_addr, one cycle late
    output cb_write_t   cb_wr,       // one record per leaf
    output logic        busy,
    output logic        done
);

    localparam int PATH_W = CODE_BITS + 1;  // moves plus marker

    cb_state_t         state;
    logic [PATH_W-1:0] path;       // marker above the moves, newest move in bit 0
    code_len_t         track_len;  // moves held in path
    code_len_t         track_pos;  // moves retraced from the root
    node_idx_t         root_q;
    logic              wait_q;     // node read still in flight

    logic [PATH_W-1:0] path_l;     // path with a left move pushed
    logic [PATH_W-1:0] path_r;     // path with a right move pushed
    code_len_t         leaf_len;   // code length of a leaf child
    logic              len_ok;     // that code fits in CODE_BITS
    logic              trk_bit;    // next move on the re-walk
    child_t            trk_child;

    // leaf record, marker bit masked out of the code
    function automatic cb_write_t leaf_rec(child_t c, logic [PATH_W-1:0] p);
        cb_write_t r;
        r.valid      = len_ok;  // overlong codes are dropped
        r.sym        = c[7:0];
        r.entry.len  = leaf_len;
        r.entry.bits = code_bits_t'(p[CODE_BITS-1:0]) & ~(code_bits_t'(1) << leaf_len);
        return r;
    endfunction

    assign path_l    = {path[PATH_W-2:0], 1'b0};
    assign path_r    = {path[PATH_W-2:0], 1'b1};
    assign leaf_len  = track_len + 1'b1;
    assign len_ok    = int'(leaf_len) <= CODE_BITS;
    assign trk_bit   = path[track_len - track_pos - 1'b1];  // oldest move sits highest
    assign trk_child = trk_bit ? node.right : node.left;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= FINISH;  // idle with done low
            path      <= PATH_W'(1);
            track_len <= '0;
            track_pos <= '0;
            root_q    <= '0;
            node_addr <= '0;
            wait_q    <= 1'b0;
            cb_wr     <= '0;
            busy      <= 1'b0;
            done      <= 1'b0;
        end else begin
            cb_wr.valid <= 1'b0;  // pulse only
            if (start) begin
                state     <= INIT;
                path      <= PATH_W'(1);  // marker only, empty path
                track_len <= '0;
                track_pos <= '0;
                root_q    <= root;
                wait_q    <= 1'b0;
                busy      <= 1'b1;
                done      <= 1'b0;
            end else begin
                case (state)
                    INIT: begin
                        if (!clear_busy) begin  // table wiped, walk may write
                            node_addr <= root_q;
                            wait_q    <= 1'b1;
                            state     <= LEFT;
                        end
                    end
                    LEFT: begin
                        if (wait_q) begin
                            wait_q <= 1'b0;
                        end else begin
                            path      <= path_l;
                            track_len <= leaf_len;
                            if (node.left[8]) begin  // descend left
                                node_addr <= node.left[6:0];
                                wait_q    <= 1'b1;
                            end else begin
                                cb_wr <= leaf_rec(node.left, path_l);
                                state <= BACKTRACK;  // node stays, right side next
                            end
                        end
                    end
                    RIGHT: begin
                        if (wait_q) begin
                            wait_q <= 1'b0;
                        end else begin
                            path      <= path_r;
                            track_len <= leaf_len;
                            wait_q    <= 1'b1;
                            if (node.right[8]) begin  // descend right, then go left again
                                node_addr <= node.right[6:0];
                                state     <= LEFT;
                            end else begin
                                cb_wr     <= leaf_rec(node.right, path_r);
                                node_addr <= root_q;  // no stack, re-walk from the root
                                track_pos <= '0;
                                state     <= TRACK;
                            end
                        end
                    end
                    TRACK: begin
                        // stop at the parent of the newest move
                        if (wait_q) begin
                            wait_q <= 1'b0;
                        end else if (track_pos + 1'b1 < track_len) begin
                            node_addr <= trk_child[6:0];
                            track_pos <= track_pos + 1'b1;
                            wait_q    <= 1'b1;
                        end else begin
                            track_pos <= '0;
                            state     <= BACKTRACK;
                        end
                    end
                    BACKTRACK: begin
                        path      <= path >> 1;
                        track_len <= track_len - 1'b1;
                        if (!path[0]) begin
                            state <= RIGHT;  // left done here, node is the parent
                        end else if (track_len == code_len_t'(1)) begin
                            state <= FINISH;  // right move of the root popped
                            busy  <= 1'b0;
                            done  <= 1'b1;
                        end else begin
                            node_addr <= root_q;
                            wait_q    <= 1'b1;
                            state     <= TRACK;
                        end
                    end
                    default: begin
                        state <= FINISH;  // hold until the next start
                    end
                endcase
            end
        end
    end

endmodule

// File: codebook/code_table.sv
`timescale 1ns/1ps

module code_table import huff_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,       // begins the wipe
    input  cb_write_t cb_wr,       // leaf records from the walk
    output logic      clear_busy,  // high for 256 cycles after start
    input  sym_t      raddr,       // host read symbol
    output cb_entry_t rdata        // entry at raddr, one cycle later
);

    cb_entry_t mem [SYM_COUNT];
    sym_t      clr_idx;  // wipe pointer

    // wipe sequencer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clear_busy <= 1'b0;
            clr_idx    <= '0;
        end else if (start) begin
            clear_busy <= 1'b1;
            clr_idx    <= '0;
        end else if (clear_busy) begin
            clr_idx <= clr_idx + 1'b1;
            if (clr_idx == sym_t'(SYM_COUNT - 1)) begin
                clear_busy <= 1'b0;  // last entry zeroed this cycle
            end
        end
    end

    // single write port, the wipe wins
    always_ff @(posedge clk) begin
        if (clear_busy) begin
            mem[clr_idx] <= '0;
        end else if (cb_wr.valid) begin
            mem[cb_wr.sym] <= cb_wr.entry;
        end
    end

    // host read
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// File: verilog/huff_codebook_top.sv
`timescale 1ns/1ps

module huff_codebook_top import huff_pkg::*; #(
    parameter int CODE_BITS = 24,  // longest code held
    parameter int ADDR_W    = 12   // AXI address width
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [ADDR_W-1:0] awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  axi_data_t         wdata,
    input  logic              wvalid,
    output logic              wready,
    output axi_resp_t         bresp,
    output logic              bvalid,
    input  logic              bready,
    input  logic [ADDR_W-1:0] araddr,
    input  logic              arvalid,
    output logic              arready,
    output axi_data_t         rdata,
    output axi_resp_t         rresp,
    output logic              rvalid,
    input  logic              rready
);

    logic        start;       // walk and wipe kick
    node_idx_t   root;
    logic        busy;
    logic        done;
    logic        node_we;     // host node write
    node_idx_t   node_waddr;
    htree_node_t node_wdata;
    node_idx_t   walk_addr;   // walk node read
    htree_node_t walk_node;
    cb_write_t   cb_wr;       // leaf records
    logic        clear_busy;
    sym_t        tab_raddr;   // host code read
    cb_entry_t   tab_rdata;

    axil_regs #(.ADDR_W(ADDR_W)) axil_regs_i (
        .clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .start, .root, .busy, .done,
        .node_we, .node_addr(node_waddr), .node_wdata,
        .tab_raddr, .tab_rdata
    );

    htree_mem htree_mem_i (
        .clk, .we(node_we), .waddr(node_waddr), .wdata(node_wdata),
        .raddr(walk_addr), .rdata(walk_node)
    );

    cb_synthesis #(.CODE_BITS(CODE_BITS)) cb_synthesis_i (
        .clk, .rst, .start, .root, .clear_busy,
        .node_addr(walk_addr), .node(walk_node), .cb_wr, .busy, .done
    );

    code_table code_table_i (
        .clk, .rst, .start, .cb_wr, .clear_busy,
        .raddr(tab_raddr), .rdata(tab_rdata)
    );

endmodule

// File: bench/huff_codebook_assertions.sv
`timescale 1ns/1ps

module huff_codebook_assertions import huff_pkg::*; #(
    parameter int CODE_BITS = 24
) (
    input logic      clk,
    input logic      rst,
    input logic      bvalid,
    input logic      bready,
    input logic      rvalid,
    input logic      rready,
    input logic      busy,
    input logic      done,
    input logic      depth_valid,  // a walk is running
    input code_len_t depth         // moves taken from the root
);

    // responses hold until the master takes them
    bresp_held: assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");
    rresp_held: assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    status_excl: assert property (@(posedge clk) disable iff (rst) !(busy && done))
        else $error("busy and done high together");

    code_fits: assert property (@(posedge clk) disable iff (rst)
                                depth_valid |-> int'(depth) <= CODE_BITS)
        else $error("walk went deeper than CODE_BITS");  // that leaf's code is dropped

endmodule

bind axil_regs huff_codebook_assertions axil_checks_i (
    .clk, .rst, .bvalid, .bready, .rvalid, .rready, .busy, .done,
    .depth_valid(1'b0), .depth(5'd0)  // no walk on the bus side
);

bind cb_synthesis huff_codebook_assertions #(.CODE_BITS(CODE_BITS)) walk_checks_i (
    .clk, .rst, .bvalid(1'b0), .bready(1'b0), .rvalid(1'b0), .rready(1'b0), .busy, .done,
    .depth_valid(busy), .depth(track_len)
);

// File: bench/huff_codebook_tb.sv
`timescale 1ns/1ps

module huff_codebook_tb import huff_pkg::*; ();

    localparam int CODE_BITS   = 24;
    localparam int ADDR_W      = 12;
    localparam int N_TREES     = 30;
    localparam int WALK_CYC    = 256 + 2 * 60 * (2 * CODE_BITS + 4);  // wipe plus every re-walk
    localparam int AXI_CYC     = 12 * (NODE_COUNT + SYM_COUNT + 64);  // bus ops of one tree
    localparam int CYCLE_LIMIT = (N_TREES + 3) * (20 * WALK_CYC + AXI_CYC);

    logic clk, rst;
    logic [ADDR_W-1:0] awaddr, araddr;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    axi_data_t wdata, rdata;
    axi_resp_t bresp, rresp;

    logic [31:0] lfsr = 32'h0b2f_1358;
    int cycles = 0;
    int errors = 0;
    int checks = 0;
    int tests  = 0;

    child_t            lc [NODE_COUNT];        // model tree, left children
    child_t            rc [NODE_COUNT];        // right children
    int                exp_len [SYM_COUNT];    // 0 for symbols not in the tree
    logic [CODE_W-1:0] exp_code [SYM_COUNT];
    bit                sym_used [SYM_COUNT];
    node_idx_t         slot_par [64];          // open leaf slots while splitting
    bit                slot_side [64];
    int                slot_dep [64];
    int                n_slots, n_int;

    huff_codebook_top #(.CODE_BITS(CODE_BITS), .ADDR_W(ADDR_W)) huff_codebook_top_i (
        .clk, .rst, .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the walk or a bus transfer never finished", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic logic lfsr_step();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) lfsr = lfsr ^ 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
        return b;
    endfunction

    function automatic int unsigned rand_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) v = (v << 1) | int'(lfsr_step());
        return v;
    endfunction

    task step();  // inputs change 2 ns after the edge
        @(posedge clk);
        #2;
    endtask

    task report_mismatch(input string name, input axi_data_t exp, input axi_data_t act);
        $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        errors++;
    endtask

    task axi_write(input logic [ADDR_W-1:0] a, input axi_data_t d, output axi_resp_t resp);
        int stall;
        awaddr  = a;
        wdata   = d;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do step(); while (!(awready && wready));  // both seen, next edge takes aw and w
        step();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) step();
        stall = int'(rand_bits(2));   // 0 to 3 cycles of back-pressure
        repeat (stall) step();
        resp   = bresp;
        bready = 1'b1;
        step();
        bready = 1'b0;
        if (bvalid) begin
            $display("write response at 0x%h came twice, seen at %0t ns", a, $time);
            errors++;
        end
    endtask

    task axi_read(input logic [ADDR_W-1:0] a, output axi_data_t d);
        int stall;
        araddr  = a;
        arvalid = 1'b1;
        do step(); while (!arready);
        step();
        arvalid = 1'b0;
        while (!rvalid) step();
        stall = int'(rand_bits(2));
        repeat (stall) step();
        d      = rdata;
        checks++;
        if (rresp != RESP_OKAY) report_mismatch("rresp", axi_data_t'(RESP_OKAY), axi_data_t'(rresp));
        rready = 1'b1;
        step();
        rready = 1'b0;
        if (rvalid) begin
            $display("read response at 0x%h came twice, seen at %0t ns", a, $time);
            errors++;
        end
    endtask

    function automatic void clear_model();
        for (int s = 0; s < SYM_COUNT; s++) begin
            exp_len[s]  = 0;
            exp_code[s] = '0;
            sym_used[s] = 1'b0;
        end
    endfunction

    // random splitting of leaf slots, depth held to CODE_BITS
    function automatic void build_tree(input int n_leaves, input node_idx_t base);
        int pick;
        node_idx_t nd;
        sym_t s;
        n_int   = 1;
        n_slots = 2;
        slot_par[0]  = base;
        slot_side[0] = 1'b0;
        slot_dep[0]  = 1;
        slot_par[1]  = base;
        slot_side[1] = 1'b1;
        slot_dep[1]  = 1;
        while (n_slots < n_leaves) begin
            pick = int'(rand_bits(6)) % n_slots;
            if (slot_dep[pick] < CODE_BITS) begin
                nd = node_idx_t'(int'(base) + n_int);
                n_int++;
                if (slot_side[pick]) rc[slot_par[pick]] = {2'b10, nd};
                else lc[slot_par[pick]] = {2'b10, nd};
                slot_par[n_slots]  = nd;       // new right slot
                slot_side[n_slots] = 1'b1;
                slot_dep[n_slots]  = slot_dep[pick] + 1;
                slot_par[pick]     = nd;       // split slot becomes the left one
                slot_side[pick]    = 1'b0;
                slot_dep[pick]     = slot_dep[pick] + 1;
                n_slots++;
            end
        end
        for (int i = 0; i < n_slots; i++) begin
            do s = sym_t'(rand_bits(8)); while (sym_used[s]);  // distinct symbols
            sym_used[s] = 1'b1;
            if (slot_side[i]) rc[slot_par[i]] = {1'b0, s};
            else lc[slot_par[i]] = {1'b0, s};
        end
    endfunction

    // left branch appends 0, right appends 1, explicit stack of pending nodes
    function automatic void expect_codes(input node_idx_t root);
        node_idx_t         q_node [$];
        logic [CODE_W-1:0] q_code [$];
        int                q_len [$];
        node_idx_t         n;
        logic [CODE_W-1:0] code, next;
        int                len;
        child_t            c;
        q_node.push_back(root);
        q_code.push_back('0);
        q_len.push_back(0);
        while (q_node.size() > 0) begin
            n    = q_node.pop_back();
            code = q_code.pop_back();
            len  = q_len.pop_back();
            for (int side = 0; side < 2; side++) begin
                c    = (side == 1) ? rc[n] : lc[n];
                next = {code[CODE_W-2:0], 1'(side)};
                if (c[8]) begin
                    q_node.push_back(c[6:0]);
                    q_code.push_back(next);
                    q_len.push_back(len + 1);
                end else begin
                    exp_code[c[7:0]] = next;
                    exp_len[c[7:0]]  = len + 1;
                end
            end
        end
    endfunction

    function automatic axi_data_t start_word(input node_idx_t r);
        return {17'b0, r, 7'b0, 1'b1};  // root in 14:8, start in bit 0
    endfunction

    task wait_done();
        axi_data_t d;
        do axi_read(ADDR_W'(STATUS_ADDR), d); while (d[1:0] == 2'b01);  // poll while busy
        checks++;
        if (d != 32'h2) report_mismatch("status", 32'h2, d);
    endtask

    task check_table();  // every symbol, absent ones must read zero
        axi_data_t d, exp;
        for (int s = 0; s < SYM_COUNT; s++) begin
            axi_read(ADDR_W'(CODE_BASE + 4 * s), d);
            exp = {3'b000, 5'(exp_len[s]), exp_code[s]};
            checks++;
            if (d != exp) report_mismatch($sformatf("code[%02h]", s), exp, d);
        end
    endtask

    task run_tree(input node_idx_t root, input bit restart);
        axi_data_t d;
        axi_resp_t resp;
        node_idx_t n;
        for (int k = 0; k < n_int; k++) begin
            n = node_idx_t'(int'(root) + k);
            axi_write(ADDR_W'(NODE_BASE + 4 * int'(n)), {14'b0, rc[n], lc[n]}, resp);
        end
        axi_write(ADDR_W'(CTRL_ADDR), start_word(root), resp);
        if (restart) begin
            axi_write(ADDR_W'(CTRL_ADDR), start_word(root + 1'b1), resp);  // must be ignored
            axi_read(ADDR_W'(STATUS_ADDR), d);
            checks++;
            if (d != 32'h1) report_mismatch("status while busy", 32'h1, d);
        end
        wait_done();
        check_table();
    endtask

    task finish_test(input string name, input int e0);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == e0) ? "passed" : "failed");
    endtask

    initial begin
        int        e0, n_leaves;
        node_idx_t base;
        axi_data_t d;
        axi_resp_t resp;
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        clear_model();
        repeat (2) @(posedge clk);
        #2 rst = 1'b0;

        e0 = errors;
        axi_read(ADDR_W'(STATUS_ADDR), d);
        checks++;
        if (d != '0) report_mismatch("status", '0, d);
        axi_write(ADDR_W'(STATUS_ADDR), 32'hffff_ffff, resp);
        checks++;
        if (resp != RESP_OKAY) report_mismatch("bresp", axi_data_t'(RESP_OKAY), axi_data_t'(resp));
        finish_test("status after reset", e0);

        e0 = errors;
        clear_model();
        n_int = 1;
        lc[9] = {1'b0, 8'h41};  // code 0
        rc[9] = {1'b0, 8'h5a};  // code 1
        expect_codes(7'd9);
        run_tree(7'd9, 1'b0);
        finish_test("single node tree", e0);

        for (int t = 0; t <= N_TREES; t++) begin  // last tree gets a second start while busy
            e0 = errors;
            clear_model();
            n_leaves = 2 + int'(rand_bits(6)) % 59;
            base     = node_idx_t'(rand_bits(6));
            build_tree(n_leaves, base);
            expect_codes(base);
            run_tree(base, t == N_TREES);
            finish_test($sformatf("%s tree, %0d leaves, root %0d",
                        (t == N_TREES) ? "restarted" : "random", n_leaves, base), e0);
        end

        $display("%0d tests, %0d checks, %0d errors, %0d cycles", tests, checks, errors, cycles);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: huff_codebook.f
common/huff_pkg.sv
verilog/axil_regs.sv
verilog/htree_mem.sv
codebook/cb_synthesis.sv
codebook/code_table.sv
verilog/huff_codebook_top.sv
bench/huff_codebook_assertions.sv
bench/huff_codebook_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module huff_codebook_tb -f huff_codebook.f

out=$(./obj_dir/Vhuff_codebook_tb) || true
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
